// File: hw/cmd_pkg.sv
// Shared widths, opcodes and word layouts for the command-stream front end
// Imported by every RTL block of the command parser
`default_nettype none

package cmd_pkg;

    localparam int data_w         = 32;
    localparam int addr_w         = 16;
    localparam int bytes_per_beat = 4;
    localparam int beat_shift     = 2;
    localparam int imm_w          = 28;
    // Byte count with the sub-beat bits dropped
    localparam int count_w        = imm_w - beat_shift;

    typedef logic [data_w-1:0] data_t;
    typedef logic [addr_w-1:0] addr_t;

    typedef enum logic [3:0] {
        op_nop    = 4'd0,
        op_store  = 4'd5,
        op_load   = 4'd6,
        op_memset = 4'd7,
        op_stream = 4'd8
    } opcode_e;

    typedef struct packed {
        opcode_e          op;
        logic [imm_w-1:0] imm;
    } cmd_hdr_t;

    // Same stream word, seen as a header or as an address/value word
    typedef union packed {
        cmd_hdr_t hdr;
        data_t    raw;
    } cmd_word_u;

    typedef struct packed {
        data_t data;
        logic  last;
    } stream_beat_t;

    typedef enum logic [2:0] {
        route_hdr,
        route_stream,
        route_store,
        route_load,
        route_memset
    } route_e;

endpackage

`default_nettype wire

// File: hw/cmd_sequencer.sv
// Command FSM: decodes header, address and value words from the input stream
// and starts the counter, address generator and router for each command
`timescale 1ns/1ns
`default_nettype none

module cmd_sequencer import cmd_pkg::*;
(
    input  wire                 aclk,
    input  wire                 resetn,

    input  wire                 s_cmd_tvalid,
    input  wire stream_beat_t   s_cmd_beat,

    input  wire                 count_zero,
    input  wire                 addr_busy,
    input  wire                 sink_idle,

    output logic                hdr_ready,
    output route_e              route,
    output logic                count_load,
    output logic [count_w-1:0]  count_value,
    output logic                addr_start,
    output addr_t               start_addr,
    output logic                is_write,
    output logic                value_load
);

    typedef enum logic [2:0] {
        st_idle,
        st_header,
        st_address,
        st_value,
        st_run
    } state_e;

    state_e               state;
    route_e               route_q;
    opcode_e              op_q;
    logic [count_w-1:0]   beats_q;
    cmd_word_u            word;
    logic [count_w-1:0]   hdr_beats;
    logic                 take;
    logic                 done;

    assign word      = s_cmd_beat.data;
    // Round the byte count down to whole beats
    assign hdr_beats = word.hdr.imm[imm_w-1:beat_shift];

    assign hdr_ready = (state == st_header) || (state == st_address) || (state == st_value);
    assign take      = s_cmd_tvalid && hdr_ready;
    assign done      = count_zero && sink_idle && !addr_busy;

    // STREAM loads the counter straight from the header, the others on the address word
    assign count_load  = take && (((state == st_header) && (word.hdr.op == op_stream))
                                  || (state == st_address));
    assign count_value = (state == st_header) ? hdr_beats : beats_q;

    assign addr_start  = take && (state == st_address);
    assign start_addr  = word.raw[addr_w-1:0];
    assign is_write    = (op_q == op_store) || (op_q == op_memset);
    assign value_load  = take && (state == st_value);

    assign route = route_q;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state   <= st_idle;
            route_q <= route_hdr;
            op_q    <= op_nop;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    state <= st_header;
                end
                st_header:
                begin
                    if (take)
                    begin
                        op_q <= word.hdr.op;
                        case (word.hdr.op)
                            op_store, op_load, op_memset:
                            begin
                                state <= st_address;
                            end
                            op_stream:
                            begin
                                route_q <= route_stream;
                                state   <= st_run;
                            end
                            // NOP and unknown opcodes wait for the next header
                            default:
                            begin
                                state <= st_header;
                            end
                        endcase
                    end
                end
                st_address:
                begin
                    if (take)
                    begin
                        if (op_q == op_memset)
                        begin
                            state <= st_value;
                        end
                        else
                        begin
                            route_q <= (op_q == op_store) ? route_store : route_load;
                            state   <= st_run;
                        end
                    end
                end
                st_value:
                begin
                    if (take)
                    begin
                        route_q <= route_memset;
                        state   <= st_run;
                    end
                end
                st_run:
                begin
                    if (done)
                    begin
                        route_q <= route_hdr;
                        state   <= st_idle;
                    end
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Beat count kept for commands that start on a later word
    always_ff @(posedge aclk)
    begin
        if (take && (state == st_header))
        begin
            beats_q <= hdr_beats;
        end
    end

endmodule

`default_nettype wire

// File: hw/beat_counter.sv
// Remaining-beat counter for the command in progress
// Loaded by the sequencer, decremented by the router per accepted source beat
`timescale 1ns/1ns
`default_nettype none

module beat_counter import cmd_pkg::*;
(
    input  wire                 aclk,
    input  wire                 resetn,

    input  wire                 count_load,
    input  wire [count_w-1:0]   count_value,
    input  wire                 beat_take,

    output logic                count_zero,
    output logic                count_last
);

    logic [count_w-1:0] count_q;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            count_q <= '0;
        end
        else if (count_load)
        begin
            count_q <= count_value;
        end
        else if (beat_take && (count_q != '0))
        begin
            count_q <= count_q - 1'b1;
        end
    end

    assign count_zero = (count_q == '0);
    // One beat left, so the next accepted beat closes the command
    assign count_last = (count_q == count_w'(1));

endmodule

`default_nettype wire

// File: hw/addr_generator.sv
// Issues one memory address per beat on the write or the read address channel
// Runs from the start address to the last beat of the range, one address per cycle
`timescale 1ns/1ns
`default_nettype none

module addr_generator import cmd_pkg::*;
(
    input  wire                 aclk,
    input  wire                 resetn,

    input  wire                 addr_start,
    input  wire addr_t          start_addr,
    input  wire [count_w-1:0]   count_value,
    input  wire                 is_write,

    input  wire                 mem_awready,
    input  wire                 mem_arready,

    output logic                addr_busy,
    output logic                mem_awvalid,
    output addr_t               mem_awaddr,
    output logic                mem_arvalid,
    output addr_t               mem_araddr
);

    logic   busy_q;
    logic   write_q;
    addr_t  cur_q;
    addr_t  end_q;
    addr_t  span;
    logic   accepted;

    // Range length in bytes, wrapped to the address width
    assign span     = {count_value[addr_w-beat_shift-1:0], {beat_shift{1'b0}}};
    assign accepted = write_q ? mem_awready : mem_arready;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            busy_q  <= 1'b0;
            write_q <= 1'b0;
        end
        else if (addr_start)
        begin
            // A zero count issues nothing
            busy_q  <= (count_value != '0);
            write_q <= is_write;
        end
        else if (busy_q && accepted && (cur_q == end_q))
        begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (addr_start)
        begin
            cur_q <= start_addr;
            end_q <= start_addr + span - addr_t'(bytes_per_beat);
        end
        else if (busy_q && accepted)
        begin
            cur_q <= cur_q + addr_t'(bytes_per_beat);
        end
    end

    assign addr_busy   = busy_q;
    assign mem_awvalid = busy_q && write_q;
    assign mem_arvalid = busy_q && !write_q;
    assign mem_awaddr  = cur_q;
    assign mem_araddr  = cur_q;

endmodule

`default_nettype wire

// File: hw/beat_router.sv
// Payload data path: picks source and sink from the route, registers one
// output beat and keeps a one-entry skid buffer for sink back-pressure
`timescale 1ns/1ns
`default_nettype none

module beat_router import cmd_pkg::*;
(
    input  wire                 aclk,
    input  wire                 resetn,

    input  wire route_e         route,
    input  wire                 hdr_ready,
    input  wire                 value_load,

    input  wire                 s_cmd_tvalid,
    input  wire stream_beat_t   s_cmd_beat,
    input  wire                 count_zero,
    input  wire                 count_last,
    input  wire                 m_out_tready,
    input  wire                 mem_wready,
    input  wire                 mem_rvalid,
    input  wire data_t          mem_rdata,

    output logic                s_cmd_tready,
    output logic                beat_take,
    output logic                sink_idle,
    output logic                m_out_tvalid,
    output stream_beat_t        m_out_beat,
    output logic                mem_wvalid,
    output data_t               mem_wdata,
    output logic                mem_rready
);

    logic           src_valid;
    data_t          src_data;
    logic           src_ready;
    logic           take;
    logic           sink_out;
    logic           sink_ready;
    logic           out_valid;
    logic           skid_valid;
    data_t          value_q;
    stream_beat_t   in_beat;
    stream_beat_t   out_q;
    stream_beat_t   skid_q;

    always_comb
    begin
        case (route)
            route_stream, route_store:
            begin
                src_valid = s_cmd_tvalid;
                src_data  = s_cmd_beat.data;
            end
            route_load:
            begin
                src_valid = mem_rvalid;
                src_data  = mem_rdata;
            end
            // MEMSET source never runs dry
            route_memset:
            begin
                src_valid = 1'b1;
                src_data  = value_q;
            end
            default:
            begin
                src_valid = 1'b0;
                src_data  = s_cmd_beat.data;
            end
        endcase
    end

    // Ready only from registers; drops once the skid entry is in use
    assign src_ready  = (route != route_hdr) && !count_zero && !skid_valid;
    assign take       = src_valid && src_ready;
    assign beat_take  = take;
    assign in_beat    = '{data: src_data, last: count_last};

    assign sink_out   = (route == route_stream) || (route == route_load);
    assign sink_ready = sink_out ? m_out_tready : mem_wready;
    assign sink_idle  = !out_valid && !skid_valid;

    assign s_cmd_tready = (route == route_hdr) ? hdr_ready
                        : ((route == route_stream) || (route == route_store)) && src_ready;
    assign mem_rready   = (route == route_load) && src_ready;

    assign m_out_tvalid = out_valid && sink_out;
    assign m_out_beat   = out_q;
    assign mem_wvalid   = out_valid && !sink_out;
    assign mem_wdata    = out_q.data;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (!out_valid || sink_ready)
        begin
            out_valid  <= skid_valid || take;
            skid_valid <= 1'b0;
        end
        else if (take)
        begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (value_load)
        begin
            value_q <= s_cmd_beat.data;
        end
        if (!out_valid || sink_ready)
        begin
            // Skid entry is older than any new beat
            if (skid_valid)
            begin
                out_q <= skid_q;
            end
            else if (take)
            begin
                out_q <= in_beat;
            end
        end
        else if (take)
        begin
            skid_q <= in_beat;
        end
    end

endmodule

`default_nettype wire

// File: hw/cmd_parser_top.sv
// Top level of the command-stream front end for the rasterizer memory port
// Takes the command stream, drives the memory channels and the output stream
`timescale 1ns/1ns
`default_nettype none

module cmd_parser_top import cmd_pkg::*;
(
    input  wire                 aclk,
    input  wire                 resetn,

    // Command stream in, last bit unused
    input  wire                 s_cmd_tvalid,
    output logic                s_cmd_tready,
    input  wire stream_beat_t   s_cmd_beat,

    output logic                m_out_tvalid,
    input  wire                 m_out_tready,
    output stream_beat_t        m_out_beat,

    // Memory channels
    output logic                mem_awvalid,
    input  wire                 mem_awready,
    output addr_t               mem_awaddr,

    output logic                mem_wvalid,
    input  wire                 mem_wready,
    output data_t               mem_wdata,

    output logic                mem_arvalid,
    input  wire                 mem_arready,
    output addr_t               mem_araddr,

    input  wire                 mem_rvalid,
    output logic                mem_rready,
    input  wire data_t          mem_rdata
);

    route_e               route;
    logic                 hdr_ready;
    logic                 count_load;
    logic [count_w-1:0]   count_value;
    logic                 addr_start;
    addr_t                start_addr;
    logic                 is_write;
    logic                 value_load;
    logic                 beat_take;
    logic                 count_zero;
    logic                 count_last;
    logic                 addr_busy;
    logic                 sink_idle;

    cmd_sequencer u_sequencer (
        .aclk         (aclk),
        .resetn       (resetn),
        .s_cmd_tvalid (s_cmd_tvalid),
        .s_cmd_beat   (s_cmd_beat),
        .count_zero   (count_zero),
        .addr_busy    (addr_busy),
        .sink_idle    (sink_idle),
        .hdr_ready    (hdr_ready),
        .route        (route),
        .count_load   (count_load),
        .count_value  (count_value),
        .addr_start   (addr_start),
        .start_addr   (start_addr),
        .is_write     (is_write),
        .value_load   (value_load)
    );

    beat_counter u_counter (
        .aclk        (aclk),
        .resetn      (resetn),
        .count_load  (count_load),
        .count_value (count_value),
        .beat_take   (beat_take),
        .count_zero  (count_zero),
        .count_last  (count_last)
    );

    addr_generator u_addr_gen (
        .aclk        (aclk),
        .resetn      (resetn),
        .addr_start  (addr_start),
        .start_addr  (start_addr),
        .count_value (count_value),
        .is_write    (is_write),
        .mem_awready (mem_awready),
        .mem_arready (mem_arready),
        .addr_busy   (addr_busy),
        .mem_awvalid (mem_awvalid),
        .mem_awaddr  (mem_awaddr),
        .mem_arvalid (mem_arvalid),
        .mem_araddr  (mem_araddr)
    );

    beat_router u_router (
        .aclk         (aclk),
        .resetn       (resetn),
        .route        (route),
        .hdr_ready    (hdr_ready),
        .value_load   (value_load),
        .s_cmd_tvalid (s_cmd_tvalid),
        .s_cmd_beat   (s_cmd_beat),
        .count_zero   (count_zero),
        .count_last   (count_last),
        .m_out_tready (m_out_tready),
        .mem_wready   (mem_wready),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata),
        .s_cmd_tready (s_cmd_tready),
        .beat_take    (beat_take),
        .sink_idle    (sink_idle),
        .m_out_tvalid (m_out_tvalid),
        .m_out_beat   (m_out_beat),
        .mem_wvalid   (mem_wvalid),
        .mem_wdata    (mem_wdata),
        .mem_rready   (mem_rready)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// Clock and reset source for the command parser testbench
// Reset is held low for a fixed number of cycles and released on a falling edge
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
(
    output logic aclk,
    output logic resetn
);

    localparam int period_ns    = 20;
    localparam int reset_cycles = 16;

    initial
    begin
        aclk = 1'b0;
        forever
        begin
            #(period_ns / 2) aclk = ~aclk;
        end
    end

    initial
    begin
        resetn = 1'b0;
        repeat (reset_cycles)
        begin
            @(posedge aclk);
        end
        @(negedge aclk);
        resetn <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/cmd_parser_tb.sv
// Self-checking testbench for the command parser top level
// Runs the cases in tb/cmd_parser_tests.txt against a 64-word memory model,
// with seeded random gaps and back-pressure on every channel
`timescale 1ns/1ns
`default_nettype none

module cmd_parser_tb import cmd_pkg::*;
();

    localparam int mem_words     = 64;
    localparam int test_timeout  = 3000;
    localparam int reset_timeout = 100;

    logic            aclk;
    logic            resetn;
    logic            s_cmd_tvalid;
    logic            s_cmd_tready;
    stream_beat_t    s_cmd_beat;
    logic            m_out_tvalid;
    logic            m_out_tready;
    stream_beat_t    m_out_beat;
    logic            mem_awvalid;
    logic            mem_awready;
    addr_t           mem_awaddr;
    logic            mem_wvalid;
    logic            mem_wready;
    data_t           mem_wdata;
    logic            mem_arvalid;
    logic            mem_arready;
    addr_t           mem_araddr;
    logic            mem_rvalid;
    logic            mem_rready;
    data_t           mem_rdata;

    // Memory model and the contents it should hold after each test
    data_t           mem [mem_words];
    data_t           exp_mem [mem_words];
    data_t           cmd_q [$];
    stream_beat_t    out_q [$];
    logic [5:0]      aw_q [$];
    data_t           w_q [$];
    logic [5:0]      rd_q [$];
    int              cmd_idx;
    logic            cmd_fire;
    logic            rd_fire;
    logic            pressure;
    logic            timed_out;
    logic [15:0]     lfsr_q;
    int              error_count;
    int              check_count;
    logic [8*16-1:0] test_name;

    tb_clock_gen u_clock_gen (
        .aclk   (aclk),
        .resetn (resetn)
    );

    cmd_parser_top dut (
        .aclk         (aclk),
        .resetn       (resetn),
        .s_cmd_tvalid (s_cmd_tvalid),
        .s_cmd_tready (s_cmd_tready),
        .s_cmd_beat   (s_cmd_beat),
        .m_out_tvalid (m_out_tvalid),
        .m_out_tready (m_out_tready),
        .m_out_beat   (m_out_beat),
        .mem_awvalid  (mem_awvalid),
        .mem_awready  (mem_awready),
        .mem_awaddr   (mem_awaddr),
        .mem_wvalid   (mem_wvalid),
        .mem_wready   (mem_wready),
        .mem_wdata    (mem_wdata),
        .mem_arvalid  (mem_arvalid),
        .mem_arready  (mem_arready),
        .mem_araddr   (mem_araddr),
        .mem_rvalid   (mem_rvalid),
        .mem_rready   (mem_rready),
        .mem_rdata    (mem_rdata)
    );

    // 16-bit Galois LFSR, one step per random bit
    function automatic logic lfsr_bit();
        logic lsb;
        lsb    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (lsb)
        begin
            lfsr_q = lfsr_q ^ 16'hb400;
        end
        return lsb;
    endfunction

    // Ready about three cycles in four when back-pressure is on
    function automatic logic ready_draw();
        logic a;
        logic b;
        if (!pressure)
        begin
            return 1'b1;
        end
        a = lfsr_bit();
        b = lfsr_bit();
        return a || b;
    endfunction

    function automatic data_t fill_word(input logic [5:0] idx);
        return {8'hee, 2'b00, idx, 10'h000, ~idx};
    endfunction

    task automatic start_test();
        cmd_q.delete();
        out_q.delete();
        cmd_idx = 0;
        for (int i = 0; i < mem_words; i++)
        begin
            mem[i]     = fill_word(6'(i));
            exp_mem[i] = fill_word(6'(i));
        end
    endtask

    task automatic check_reset_state();
        check_count++;
        assert (!s_cmd_tready && !m_out_tvalid && !mem_awvalid && !mem_wvalid
                && !mem_arvalid && !mem_rready && (dut.route == route_hdr))
        else
        begin
            error_count++;
            $display("Handshake outputs or route are not idle during reset at %0t", $time);
        end
    endtask

    task automatic check_address(input addr_t addr);
        check_count++;
        assert ((addr[addr_w-1:8] == '0) && (addr[1:0] == 2'b00))
        else
        begin
            error_count++;
            $display("Address %h at %0t is unaligned or beyond the memory", addr, $time);
        end
    endtask

    // One cycle of stimulus and bookkeeping, called on each falling edge
    task automatic step_cycle();
        stream_beat_t want;
        logic [5:0]   waddr;
        data_t        wdata;
        // Beats taken at the last rising edge leave the input channels
        if (cmd_fire)
        begin
            s_cmd_tvalid = 1'b0;
            cmd_idx++;
        end
        if (rd_fire)
        begin
            mem_rvalid = 1'b0;
            rd_q.delete(0);
        end
        if (!s_cmd_tvalid && (cmd_idx < cmd_q.size()) && ready_draw())
        begin
            s_cmd_tvalid = 1'b1;
            s_cmd_beat   = '{data: cmd_q[cmd_idx], last: 1'b0};
        end
        // Read data returns in address order
        if (!mem_rvalid && (rd_q.size() > 0) && ready_draw())
        begin
            mem_rvalid = 1'b1;
            mem_rdata  = mem[rd_q[0]];
        end
        m_out_tready = ready_draw();
        mem_awready  = ready_draw();
        mem_wready   = ready_draw();
        mem_arready  = ready_draw();

        // DUT outputs hold still until the next rising edge
        cmd_fire = s_cmd_tvalid && s_cmd_tready;
        rd_fire  = mem_rvalid && mem_rready;
        if (m_out_tvalid && m_out_tready)
        begin
            check_count++;
            assert (out_q.size() > 0)
            else
            begin
                error_count++;
                $display("Output beat %h at %0t was not expected in test %0s",
                         m_out_beat.data, $time, test_name);
            end
            if (out_q.size() > 0)
            begin
                want = out_q.pop_front();
                check_count++;
                assert (m_out_beat.data == want.data)
                else
                begin
                    error_count++;
                    $display("[ERROR] %0t m_out_beat.data got %h expected %h in test %0s",
                             $time, m_out_beat.data, want.data, test_name);
                end
                check_count++;
                assert (m_out_beat.last == want.last)
                else
                begin
                    error_count++;
                    $display("[ERROR] %0t m_out_beat.last got %b expected %b in test %0s",
                             $time, m_out_beat.last, want.last, test_name);
                end
            end
        end
        if (mem_awvalid && mem_awready)
        begin
            check_address(mem_awaddr);
            aw_q.push_back(mem_awaddr[7:2]);
        end
        if (mem_wvalid && mem_wready)
        begin
            w_q.push_back(mem_wdata);
        end
        if (mem_arvalid && mem_arready)
        begin
            check_address(mem_araddr);
            rd_q.push_back(mem_araddr[7:2]);
        end
        // Write addresses and data pair up in arrival order
        while ((aw_q.size() > 0) && (w_q.size() > 0))
        begin
            waddr      = aw_q.pop_front();
            wdata      = w_q.pop_front();
            mem[waddr] = wdata;
        end
    endtask

    task automatic check_memory();
        for (int i = 0; i < mem_words; i++)
        begin
            check_count++;
            assert (mem[i] == exp_mem[i])
            else
            begin
                error_count++;
                $display("[ERROR] %0t mem[%0d] got %h expected %h in test %0s",
                         $time, i, mem[i], exp_mem[i], test_name);
            end
        end
    endtask

    task automatic run_test();
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done && (cycles < test_timeout))
        begin
            @(negedge aclk);
            step_cycle();
            cycles++;
            // Finished once everything is sent, answered and the FSM waits for a header
            done = (cmd_idx == cmd_q.size()) && !s_cmd_tvalid && s_cmd_tready
                && (out_q.size() == 0) && (rd_q.size() == 0)
                && (aw_q.size() == 0) && (w_q.size() == 0);
        end
        if (!done)
        begin
            error_count++;
            timed_out = 1'b1;
            $display("Test %0s did not finish within %0d cycles at %0t",
                     test_name, test_timeout, $time);
        end
        else
        begin
            check_memory();
        end
    endtask

    initial
    begin
        int               fd;
        int               code;
        int               wait_cycles;
        int               idx;
        int               count;
        int               pval;
        int               lastv;
        int               tests_run;
        data_t            word;
        logic             at_end;
        logic [8*16-1:0]  tok;
        logic [8*128-1:0] line;

        s_cmd_tvalid = 1'b0;
        s_cmd_beat   = '0;
        m_out_tready = 1'b0;
        mem_awready  = 1'b0;
        mem_wready   = 1'b0;
        mem_arready  = 1'b0;
        mem_rvalid   = 1'b0;
        mem_rdata    = '0;
        cmd_fire     = 1'b0;
        rd_fire      = 1'b0;
        pressure     = 1'b0;
        timed_out    = 1'b0;
        lfsr_q       = 16'd60;
        error_count  = 0;
        check_count  = 0;
        cmd_idx      = 0;
        tests_run    = 0;
        at_end       = 1'b0;
        test_name    = "reset";

        wait_cycles = 0;
        while (!resetn && (wait_cycles < reset_timeout))
        begin
            @(negedge aclk);
            wait_cycles++;
            if (!resetn && (wait_cycles == 4))
            begin
                check_reset_state();
            end
        end
        if (!resetn)
        begin
            error_count++;
            timed_out = 1'b1;
            $display("Reset was still asserted after %0d cycles", reset_timeout);
        end

        fd = $fopen("tb/cmd_parser_tests.txt", "r");
        if (fd == 0)
        begin
            error_count++;
            $display("Could not open the test data file tb/cmd_parser_tests.txt");
        end
        while ((fd != 0) && !timed_out && !at_end)
        begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1)
            begin
                at_end = 1'b1;
            end
            else if (tok == "#")
            begin
                code = $fgets(line, fd);
            end
            else if (tok == "test")
            begin
                code     = $fscanf(fd, "%s %d", test_name, pval);
                pressure = (pval != 0);
                start_test();
            end
            else if ((tok == "pre") || (tok == "mem"))
            begin
                code = $fscanf(fd, "%h %d", idx, count);
                for (int k = 0; k < count; k++)
                begin
                    code = $fscanf(fd, "%h", word);
                    if (tok == "pre")
                    begin
                        mem[idx + k] = word;
                    end
                    exp_mem[idx + k] = word;
                end
            end
            else if (tok == "cmd")
            begin
                code = $fscanf(fd, "%d", count);
                for (int k = 0; k < count; k++)
                begin
                    code = $fscanf(fd, "%h", word);
                    cmd_q.push_back(word);
                end
            end
            else if (tok == "out")
            begin
                code = $fscanf(fd, "%d", count);
                for (int k = 0; k < count; k++)
                begin
                    code = $fscanf(fd, "%h %d", word, lastv);
                    out_q.push_back('{data: word, last: (lastv != 0)});
                end
            end
            else if (tok == "run")
            begin
                run_test();
                tests_run++;
            end
            else
            begin
                error_count++;
                at_end = 1'b1;
                $display("Unknown token %0s in the test data file", tok);
            end
        end
        if (fd != 0)
        begin
            $fclose(fd);
        end
        if (tests_run == 0)
        begin
            error_count++;
            $display("No test case was run");
        end

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, check_count, error_count);
        if (error_count == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/cmd_parser_tests.txt
# test <name> <pressure 0|1>, pre/mem <word index hex> <count> <data hex ...>
# cmd <count> <words hex ...>, out <count> then <data hex> <last> pairs, run
test stream 0
cmd 4 8000000e a1a1a1a1 b2b2b2b2 c3c3c3c3
out 3 a1a1a1a1 0 b2b2b2b2 0 c3c3c3c3 1
run
test store 0
cmd 6 50000010 00000040 10000001 10000002 10000003 10000004
mem 10 4 10000001 10000002 10000003 10000004
run
test load 0
pre 20 3 cafe0000 cafe0001 cafe0002
cmd 2 6000000c 00000080
out 3 cafe0000 0 cafe0001 0 cafe0002 1
run
test memset 0
pre 27 7 77777777 00000000 00000000 00000000 00000000 00000000 88888888
cmd 3 70000014 000000a0 5a5a5a5a
mem 28 5 5a5a5a5a 5a5a5a5a 5a5a5a5a 5a5a5a5a 5a5a5a5a
run
# NOP, unknown opcodes and zero counts move nothing, then a short STREAM
test skip 0
cmd 14 00000000 3000001c f0000004 80000000 50000003 00000040 60000000 00000080
70000002 000000a0 12345678 80000008 d0d0d0d0 e1e1e1e1
out 2 d0d0d0d0 0 e1e1e1e1 1
run
test mixed 1
pre 30 4 01020304 05060708 090a0b0c 0d0e0f10
cmd 21 50000014 00000000 aa000001 aa000002 aa000003 aa000004 aa000005
60000010 000000c0 80000018 bb000001 bb000002 bb000003 bb000004 bb000005 bb000006
70000010 000000e0 9e9e9e9e 6000000c 00000004
out 13 01020304 0 05060708 0 090a0b0c 0 0d0e0f10 1
bb000001 0 bb000002 0 bb000003 0 bb000004 0 bb000005 0 bb000006 1
aa000002 0 aa000003 0 aa000004 1
mem 00 5 aa000001 aa000002 aa000003 aa000004 aa000005
mem 38 4 9e9e9e9e 9e9e9e9e 9e9e9e9e 9e9e9e9e
run
test burst 1
cmd 15 7000003c 00000040 c5c5c5c5 50000020 00000080 e0000001 e0000002 e0000003
e0000004 e0000005 e0000006 e0000007 e0000008 60000020 00000080
out 8 e0000001 0 e0000002 0 e0000003 0 e0000004 0 e0000005 0 e0000006 0
e0000007 0 e0000008 1
mem 10 15 c5c5c5c5 c5c5c5c5 c5c5c5c5 c5c5c5c5 c5c5c5c5 c5c5c5c5 c5c5c5c5 c5c5c5c5
c5c5c5c5 c5c5c5c5 c5c5c5c5 c5c5c5c5 c5c5c5c5 c5c5c5c5 c5c5c5c5
mem 20 8 e0000001 e0000002 e0000003 e0000004 e0000005 e0000006 e0000007 e0000008
run

// File: verilog.f
hw/cmd_pkg.sv
hw/cmd_sequencer.sv
hw/beat_counter.sv
hw/addr_generator.sv
hw/beat_router.sv
hw/cmd_parser_top.sv
tb/tb_clock_gen.sv
tb/cmd_parser_tb.sv

// File: Bender.yml
package:
  name: cmd_parser

sources:
  - files:
      - hw/cmd_pkg.sv
      - hw/cmd_sequencer.sv
      - hw/beat_counter.sv
      - hw/addr_generator.sv
      - hw/beat_router.sv
      - hw/cmd_parser_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/cmd_parser_tb.sv
